/* capture_pkg.sv */
package capture_pkg;

  localparam int BUF_AW       = 6;               // 64 sample buffer
  localparam int BUF_DEPTH    = 1 << BUF_AW;
  localparam int ADC_DIV      = 4;               // 2 high, 2 low
  localparam int ADC_PW       = $clog2(ADC_DIV);
  localparam int DIGIT_CYCLES = 16;              // Dwell per display digit
  localparam int DIG_CW       = $clog2(DIGIT_CYCLES);
  localparam int NUM_DIGITS   = 6;

  typedef logic [7:0]        sample_t;
  typedef logic [BUF_AW-1:0] buf_addr_t;
  typedef logic [7:0]        count_t;
  typedef logic [3:0]        decim_t;
  typedef logic [3:0]        cmd_t;
  typedef logic [15:0]       word_t;

  // Pi port command codes
  localparam cmd_t CMD_ARM         = 4'd1;
  localparam cmd_t CMD_STOP        = 4'd2;
  localparam cmd_t CMD_RD_RST      = 4'd3;
  localparam cmd_t CMD_READ        = 4'd4;
  localparam cmd_t CMD_STATUS      = 4'd5;
  localparam cmd_t CMD_DECIM_SHIFT = 4'd6;

  typedef enum logic [1:0] {
    CAP_IDLE,
    CAP_RUN,
    CAP_DONE
  } cap_state_t;

endpackage

/* adc_sampler.sv */
module adc_sampler (
  input  logic                 sys_clk,
  input  logic                 rst,
  input  capture_pkg::sample_t adc_data,
  output logic                 adc_clk,
  output capture_pkg::sample_t sample,
  output logic                 sample_valid
);
  import capture_pkg::*;

  localparam logic [ADC_PW-1:0] PH_FALL = ADC_PW'(ADC_DIV / 2 - 1);
  localparam logic [ADC_PW-1:0] PH_LAST = ADC_PW'(ADC_DIV - 1);

  logic [ADC_PW-1:0] phase;  // Position inside one adc_clk period

  always_ff @(posedge sys_clk) begin
    if (rst) begin
      phase        <= '0;
      adc_clk      <= 1'b1;  // Period starts in the high half
      sample_valid <= 1'b0;
    end else begin
      sample_valid <= 1'b0;
      if (phase == PH_LAST) begin
        phase   <= '0;
        adc_clk <= 1'b1;     // Rising edge, ADC updates its output
      end else begin
        phase <= phase + 1'b1;
      end
      if (phase == PH_FALL) begin
        adc_clk      <= 1'b0;
        sample_valid <= 1'b1; // One strobe per conversion
      end
    end
  end

  // Data is stable across the high half, take it at the fall
  always_ff @(posedge sys_clk) begin
    if (phase == PH_FALL) begin
      sample <= adc_data;
    end
  end

endmodule

/* capture_ctrl.sv */
module capture_ctrl (
  input  logic                   sys_clk,
  input  logic                   rst,
  input  capture_pkg::sample_t   sample,
  input  logic                   sample_valid,
  input  logic                   arm,
  input  logic                   stop,
  input  capture_pkg::decim_t    decim,
  output logic                   wr_en,
  output capture_pkg::buf_addr_t wr_addr,
  output capture_pkg::sample_t   wr_data,
  output logic                   busy,
  output logic                   done,
  output capture_pkg::count_t    count
);
  import capture_pkg::*;

  cap_state_t state;
  decim_t     skip_cnt;  // Samples still to drop before the next store

  assign busy = (state == CAP_RUN);
  assign done = (state == CAP_DONE);

  always_ff @(posedge sys_clk) begin
    if (rst) begin
      state    <= CAP_IDLE;
      skip_cnt <= '0;
      wr_en    <= 1'b0;
      wr_addr  <= '0;
      count    <= '0;
    end else begin
      wr_en <= 1'b0;
      if (wr_en) begin
        wr_addr <= wr_addr + 1'b1;
        count   <= count + 1'b1;
        if (state == CAP_RUN && count == count_t'(BUF_DEPTH - 1)) begin
          state <= CAP_DONE;  // Buffer full
        end
      end
      if (state == CAP_RUN && sample_valid) begin
        if (skip_cnt == '0) begin
          wr_en    <= 1'b1;
          skip_cnt <= decim;
        end else begin
          skip_cnt <= skip_cnt - 1'b1;
        end
      end
      if (stop) begin
        state <= CAP_DONE;
      end
      if (arm) begin         // Fresh capture wins over everything
        state    <= CAP_RUN;
        wr_en    <= 1'b0;
        wr_addr  <= '0;
        count    <= '0;
        skip_cnt <= '0;
      end
    end
  end

  always_ff @(posedge sys_clk) begin
    if (sample_valid) begin
      wr_data <= sample;    // Held until the write cycle
    end
  end

endmodule

/* capture_buffer.sv */
module capture_buffer (
  input  logic                   sys_clk,
  input  logic                   wr_en,
  input  capture_pkg::buf_addr_t wr_addr,
  input  capture_pkg::sample_t   wr_data,
  input  capture_pkg::buf_addr_t rd_addr,
  output capture_pkg::sample_t   rd_data
);
  import capture_pkg::*;

  sample_t mem [BUF_DEPTH];  // Stands in for the SDRAM

  always_ff @(posedge sys_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  always_ff @(posedge sys_clk) begin
    rd_data <= mem[rd_addr];  // One cycle read latency
  end

endmodule

/* host_port.sv */
module host_port (
  input  logic                   sys_clk,
  input  logic                   rst,
  input  logic                   rbp_req,
  input  logic                   rbp_rst,
  input  logic                   rbp_dat,
  input  capture_pkg::cmd_t      rbp_cmd,
  output logic                   rbp_ack,
  output capture_pkg::word_t     rbp_data,
  output logic                   arm,
  output logic                   stop,
  output capture_pkg::decim_t    decim,
  input  logic                   busy,
  input  logic                   done,
  input  capture_pkg::count_t    count,
  output capture_pkg::buf_addr_t rd_addr,
  input  capture_pkg::sample_t   rd_data
);
  import capture_pkg::*;

  typedef enum logic [1:0] {
    P_IDLE,  // Waiting for req
    P_RD0,   // Low byte on its way
    P_RD1,   // High byte on its way
    P_HOLD   // Ack high or waiting for req low
  } port_state_t;

  port_state_t state;
  logic        req_s1, req_s2;
  logic        rst_s1, rst_s2;
  logic        dat_s1, dat_s2;
  cmd_t        cmd_s1, cmd_s2;
  buf_addr_t   ptr;           // Read pointer into the buffer

  // Two flop synchronisers for everything coming from the Pi
  always_ff @(posedge sys_clk) begin
    if (rst) begin
      req_s1 <= 1'b0;
      req_s2 <= 1'b0;
      rst_s1 <= 1'b0;
      rst_s2 <= 1'b0;
    end else begin
      req_s1 <= rbp_req;
      req_s2 <= req_s1;
      rst_s1 <= rbp_rst;
      rst_s2 <= rst_s1;
    end
  end

  always_ff @(posedge sys_clk) begin
    dat_s1 <= rbp_dat;
    dat_s2 <= dat_s1;
    cmd_s1 <= rbp_cmd;
    cmd_s2 <= cmd_s1;
  end

  assign rd_addr = (state == P_RD0) ? buf_addr_t'(ptr + 1'b1) : ptr;

  always_ff @(posedge sys_clk) begin
    if (rst) begin
      state   <= P_IDLE;
      rbp_ack <= 1'b0;
      arm     <= 1'b0;
      stop    <= 1'b0;
      decim   <= '0;
      ptr     <= '0;
    end else begin
      arm  <= 1'b0;
      stop <= 1'b0;
      if (rst_s2) begin       // Protocol reset
        state   <= P_HOLD;
        rbp_ack <= 1'b0;
        ptr     <= '0;
      end else begin
        case (state)
          P_IDLE: begin
            if (req_s2) begin
              state   <= (cmd_s2 == CMD_READ) ? P_RD0 : P_HOLD;
              rbp_ack <= (cmd_s2 != CMD_READ);
              case (cmd_s2)
                CMD_ARM:         arm   <= 1'b1;
                CMD_STOP:        stop  <= 1'b1;
                CMD_RD_RST:      ptr   <= '0;
                CMD_DECIM_SHIFT: decim <= {decim[2:0], dat_s2};
                default: ;
              endcase
            end
          end
          P_RD0: state <= P_RD1;
          P_RD1: begin
            state   <= P_HOLD;
            rbp_ack <= 1'b1;
            ptr     <= ptr + 2'd2; // Wraps with the buffer
          end
          P_HOLD: begin
            if (!req_s2) begin
              state   <= P_IDLE;
              rbp_ack <= 1'b0;
            end
          end
        endcase
      end
    end
  end

  // Answer word, stable while ack is high
  always_ff @(posedge sys_clk) begin
    if (state == P_IDLE && req_s2) begin
      case (cmd_s2)
        CMD_STATUS:      rbp_data <= {busy, done, 2'b00, decim, count};
        CMD_DECIM_SHIFT: rbp_data <= word_t'({decim[2:0], dat_s2});
        default:         rbp_data <= '0;
      endcase
    end else if (state == P_RD0) begin
      rbp_data[7:0] <= rd_data;
    end else if (state == P_RD1) begin
      rbp_data[15:8] <= rd_data;
    end
  end

endmodule

/* seg_led_hex.sv */
module seg_led_hex (
  input  logic                 sys_clk,
  input  logic                 rst,
  input  capture_pkg::sample_t data0,
  input  capture_pkg::sample_t data1,
  input  capture_pkg::sample_t data2,
  output logic [5:0]           seg_sel,
  output logic [7:0]           seg_led
);
  import capture_pkg::*;

  logic [DIG_CW-1:0] tick;    // Dwell counter
  logic [2:0]        digit;   // Digit being lit
  logic [3:0]        nibble;

  always_ff @(posedge sys_clk) begin
    if (rst) begin
      tick  <= '0;
      digit <= '0;
    end else if (tick == DIG_CW'(DIGIT_CYCLES - 1)) begin
      tick  <= '0;
      digit <= (digit == 3'(NUM_DIGITS - 1)) ? 3'd0 : digit + 1'b1;
    end else begin
      tick <= tick + 1'b1;
    end
  end

  assign seg_sel = ~(6'b000001 << digit);  // Active low select

  always_comb begin
    case (digit)
      3'd0:    nibble = data0[3:0];
      3'd1:    nibble = data0[7:4];
      3'd2:    nibble = data1[3:0];
      3'd3:    nibble = data1[7:4];
      3'd4:    nibble = data2[3:0];
      default: nibble = data2[7:4];
    endcase
  end

  // Segments dp,g..a active low, dp kept dark
  always_comb begin
    case (nibble)
      4'h0:    seg_led = 8'hc0;
      4'h1:    seg_led = 8'hf9;
      4'h2:    seg_led = 8'ha4;
      4'h3:    seg_led = 8'hb0;
      4'h4:    seg_led = 8'h99;
      4'h5:    seg_led = 8'h92;
      4'h6:    seg_led = 8'h82;
      4'h7:    seg_led = 8'hf8;
      4'h8:    seg_led = 8'h80;
      4'h9:    seg_led = 8'h90;
      4'ha:    seg_led = 8'h88;
      4'hb:    seg_led = 8'h83;
      4'hc:    seg_led = 8'hc6;
      4'hd:    seg_led = 8'ha1;
      4'he:    seg_led = 8'h86;
      default: seg_led = 8'h8e;
    endcase
  end

endmodule

/* capture_top.sv */
module capture_top (
  input  logic                 sys_clk,
  input  logic                 rst,
  input  capture_pkg::sample_t adc_data,
  output logic                 adc_clk,
  input  logic                 rbp_req,
  input  logic                 rbp_rst,
  input  logic                 rbp_dat,
  input  capture_pkg::cmd_t    rbp_cmd,
  output logic                 rbp_ack,
  output capture_pkg::word_t   rbp_data,
  output logic [3:0]           led,
  output logic [5:0]           seg_sel,
  output logic [7:0]           seg_led
);
  import capture_pkg::*;

  sample_t   sample;       // Latest ADC byte
  logic      sample_valid;
  logic      wr_en;
  buf_addr_t wr_addr;
  sample_t   wr_data;
  buf_addr_t rd_addr;
  sample_t   rd_data;
  logic      arm;
  logic      stop;
  decim_t    decim;
  logic      busy;
  logic      done;
  count_t    count;

  adc_sampler ins_adc_sampler (
    .sys_clk      (sys_clk),
    .rst          (rst),
    .adc_data     (adc_data),
    .adc_clk      (adc_clk),
    .sample       (sample),
    .sample_valid (sample_valid)
  );

  capture_ctrl ins_capture_ctrl (
    .sys_clk      (sys_clk),
    .rst          (rst),
    .sample       (sample),
    .sample_valid (sample_valid),
    .arm          (arm),
    .stop         (stop),
    .decim        (decim),
    .wr_en        (wr_en),
    .wr_addr      (wr_addr),
    .wr_data      (wr_data),
    .busy         (busy),
    .done         (done),
    .count        (count)
  );

  capture_buffer ins_capture_buffer (
    .sys_clk (sys_clk),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  host_port ins_host_port (
    .sys_clk  (sys_clk),
    .rst      (rst),
    .rbp_req  (rbp_req),
    .rbp_rst  (rbp_rst),
    .rbp_dat  (rbp_dat),
    .rbp_cmd  (rbp_cmd),
    .rbp_ack  (rbp_ack),
    .rbp_data (rbp_data),
    .arm      (arm),
    .stop     (stop),
    .decim    (decim),
    .busy     (busy),
    .done     (done),
    .count    (count),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data)
  );

  seg_led_hex ins_seg_led_hex (
    .sys_clk (sys_clk),
    .rst     (rst),
    .data0   (sample),
    .data1   (count),
    .data2   (sample_t'(decim)),  // Zero extended
    .seg_sel (seg_sel),
    .seg_led (seg_led)
  );

  assign led = {done, busy, rbp_ack, rbp_req};  // Port and capture state

endmodule

/* tb_capture_top.sv */
module tb_capture_top;
  import capture_pkg::*;

  localparam int ACK_TIMEOUT  = 64;    // Cycles allowed per handshake phase
  localparam int POLL_LIMIT   = 2000;  // Status polls per capture
  localparam int SCAN_TIMEOUT = 400;

  // Active-low segments dp,g..a for hex 0..f
  localparam logic [7:0] HEX_SEG [16] = '{8'hc0, 8'hf9, 8'ha4, 8'hb0, 8'h99, 8'h92, 8'h82, 8'hf8,
                                         8'h80, 8'h90, 8'h88, 8'h83, 8'hc6, 8'ha1, 8'h86, 8'h8e};

  logic       sys_clk;
  logic       rst;
  sample_t    adc_data;
  logic       adc_clk;
  logic       rbp_req;
  logic       rbp_rst;
  logic       rbp_dat;
  cmd_t       rbp_cmd;
  logic       rbp_ack;
  word_t      rbp_data;
  logic [3:0] led;
  logic [5:0] seg_sel;
  logic [7:0] seg_led;

  logic    hung = 1'b0;
  logic    cap_running = 1'b0;  // ADC model records only during a capture
  sample_t hist_val[$];         // ADC byte at each adc_clk fall
  time     hist_t[$];           // Negedge on which that fall was seen
  time     ack_time;            // Negedge where the last ack was seen high
  sample_t model_mem[BUF_DEPTH];
  int      checks = 0;
  int      errors = 0;
  int      test_errs = 0;
  int      tests_ok = 0;
  int      tests_bad = 0;

  capture_top i_capture_top (
    .sys_clk  (sys_clk),
    .rst      (rst),
    .adc_data (adc_data),
    .adc_clk  (adc_clk),
    .rbp_req  (rbp_req),
    .rbp_rst  (rbp_rst),
    .rbp_dat  (rbp_dat),
    .rbp_cmd  (rbp_cmd),
    .rbp_ack  (rbp_ack),
    .rbp_data (rbp_data),
    .led      (led),
    .seg_sel  (seg_sel),
    .seg_led  (seg_led)
  );

  initial begin : clock_gen
    sys_clk = 1'b0;
    forever #5 sys_clk = ~sys_clk;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // New byte after each adc_clk rise, record at each fall
  initial begin : adc_model
    logic        last_clk;
    logic [31:0] adc_lcg;
    last_clk = 1'b0;
    adc_lcg  = 32'd4335;
    adc_data = '0;
    forever begin
      @(negedge sys_clk);
      if (last_clk && !adc_clk && cap_running) begin
        hist_val.push_back(adc_data);
        hist_t.push_back($time);
      end
      if (!last_clk && adc_clk) begin
        adc_lcg  = lcg_next(adc_lcg);
        adc_data = adc_lcg[23:16];
      end
      last_clk = adc_clk;
    end
  end

  initial begin : hang_exit
    @(posedge hung);
    $display("test failed");
    $finish;
  end

  task automatic report_timeout(input string what);
    $display("%0t: timeout while waiting for %s", $time, what);
    hung = 1'b1;
    forever @(negedge sys_clk);  // Park here until the run ends
  endtask

  task automatic report_error(input string what);
    errors++;
    test_errs++;
    $display("%0t: %s", $time, what);
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      test_errs++;
      $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic finish_test(input int num);
    if (test_errs == 0) begin
      tests_ok++;
      $display("behavior %0d: ok", num);
    end else begin
      tests_bad++;
      $display("behavior %0d: %0d errors", num, test_errs);
    end
    test_errs = 0;
  endtask

  task automatic wait_ack(input logic level, input string what);
    int n;
    n = 0;
    while (rbp_ack !== level && n < ACK_TIMEOUT) begin
      @(negedge sys_clk);
      n++;
    end
    if (rbp_ack !== level) begin
      report_timeout(what);
    end
  endtask

  // One four-phase transfer as the Pi does it
  task automatic pi_xfer(input cmd_t cmd, input logic dat, output word_t data);
    @(negedge sys_clk);
    rbp_cmd = cmd;
    rbp_dat = dat;
    @(negedge sys_clk);
    rbp_req = 1'b1;
    wait_ack(1'b1, "ack high");
    ack_time = $time;
    data     = rbp_data;
    rbp_req  = 1'b0;
    wait_ack(1'b0, "ack low");
  endtask

  task automatic poll_done(output word_t st);
    int n;
    n  = 0;
    st = '0;
    while (!st[14] && n < POLL_LIMIT) begin
      pi_xfer(CMD_STATUS, 1'b0, st);
      n++;
    end
    if (!st[14]) begin
      report_timeout("capture done");
    end
  endtask

  function automatic int first_after(input time t);
    int i;
    i = 0;
    while (i < hist_t.size() && hist_t[i] <= t) begin
      i++;
    end
    return i;
  endfunction

  // Stores the model expects up to the negedge that saw the stop ack
  function automatic int stored_by(input int base, input int d, input time t);
    int k;
    k = 0;
    while (k < BUF_DEPTH && base + k * (d + 1) < hist_t.size()
           && hist_t[base + k * (d + 1)] <= t) begin
      k++;
    end
    return k;
  endfunction

  // Reference model, keep one sample out of every d+1
  task automatic fill_model(input int base, input int d, input int n);
    int idx;
    for (int k = 0; k < n; k++) begin
      idx = base + k * (d + 1);
      if (idx < hist_val.size()) begin
        model_mem[k] = hist_val[idx];
      end else begin
        report_error("ADC model holds too few samples for the capture");
      end
    end
  endtask

  task automatic read_back(input int n);
    word_t w;
    pi_xfer(CMD_RD_RST, 1'b0, w);
    check_word("rbp_data", w, '0);
    for (int i = 0; i < n; i += 2) begin
      pi_xfer(CMD_READ, 1'b0, w);
      check_word($sformatf("rbp_data read %0d", i), w, {model_mem[i + 1], model_mem[i]});
    end
  endtask

  function automatic int digit_of(input logic [5:0] sel);
    int dig;
    dig = -1;
    for (int i = 0; i < 6; i++) begin
      if (sel == ~(6'b000001 << i)) begin
        dig = i;
      end
    end
    return dig;
  endfunction

  initial begin : main_seq
    word_t       w;
    word_t       st;
    word_t       st2;
    time         arm_time;
    time         stop_time;
    int          d;
    int          c;
    int          n;
    int          dig;
    logic [3:0]  dbits;
    logic [5:0]  seen;
    logic [23:0] shown;
    logic [31:0] tst_lcg;

    rst     = 1'b1;
    rbp_req = 1'b0;
    rbp_rst = 1'b0;
    rbp_dat = 1'b0;
    rbp_cmd = '0;
    tst_lcg = 32'd4335;
    repeat (4) @(negedge sys_clk);
    rst = 1'b0;

    // Behavior 1
    check_word("led", word_t'(led), '0);
    pi_xfer(CMD_STATUS, 1'b0, st);
    check_word("rbp_data", st, '0);
    check_word("led[3:2]", word_t'(led[3:2]), '0);
    finish_test(1);

    // Behavior 2, full capture at decim 0
    hist_val.delete();
    hist_t.delete();
    cap_running = 1'b1;
    pi_xfer(CMD_ARM, 1'b0, w);
    arm_time = ack_time;
    check_word("rbp_data", w, '0);
    poll_done(st);
    cap_running = 1'b0;
    check_word("status", st, {1'b0, 1'b1, 2'b00, 4'd0, 8'd64});
    check_word("led", word_t'(led), 16'h0008);  // Done only
    fill_model(first_after(arm_time), 0, BUF_DEPTH);
    read_back(BUF_DEPTH);
    finish_test(2);

    // Behavior 3, random decimation shifted in msb first
    tst_lcg = lcg_next(tst_lcg);
    d       = int'(tst_lcg[27:24] % 4'd15) + 1;
    dbits   = decim_t'(d);
    for (int i = 3; i >= 0; i--) begin
      pi_xfer(CMD_DECIM_SHIFT, dbits[i], w);
      check_word("rbp_data", w, word_t'(dbits >> i));
    end
    pi_xfer(CMD_STATUS, 1'b0, st);
    check_word("status decim", word_t'(st[11:8]), word_t'(dbits));
    hist_val.delete();
    hist_t.delete();
    cap_running = 1'b1;
    pi_xfer(CMD_ARM, 1'b0, w);
    arm_time = ack_time;
    poll_done(st);
    cap_running = 1'b0;
    check_word("status", st, {1'b0, 1'b1, 2'b00, dbits, 8'd64});
    fill_model(first_after(arm_time), d, BUF_DEPTH);
    read_back(BUF_DEPTH);
    finish_test(3);

    // Behavior 4, stop part way through
    hist_val.delete();
    hist_t.delete();
    cap_running = 1'b1;
    pi_xfer(CMD_ARM, 1'b0, w);
    arm_time = ack_time;
    check_word("led", word_t'(led), 16'h0004);  // Busy only
    tst_lcg  = lcg_next(tst_lcg);
    n        = 20 + int'(tst_lcg[21:16]);
    repeat (n) @(negedge sys_clk);
    pi_xfer(CMD_STOP, 1'b0, w);
    stop_time = ack_time;
    check_word("rbp_data", w, '0);
    pi_xfer(CMD_STATUS, 1'b0, st);
    pi_xfer(CMD_STATUS, 1'b0, st2);
    cap_running = 1'b0;
    c = stored_by(first_after(arm_time), d, stop_time);
    check_word("status busy", word_t'(st[15]), '0);
    check_word("status done", word_t'(st[14]), 16'd1);
    check_word("status count", word_t'(st[7:0]), word_t'(c));
    check_word("status count again", word_t'(st2[7:0]), word_t'(c));
    fill_model(first_after(arm_time), d, c);
    read_back(c);
    finish_test(4);

    // Behavior 5, count and decim digits of the display
    shown = {4'h0, dbits, count_t'(c), 8'h00};
    seen  = '0;
    n     = 0;
    while (seen[5:2] != 4'hf && n < SCAN_TIMEOUT) begin
      @(negedge sys_clk);
      n++;
      dig = digit_of(seg_sel);
      if (dig < 0) begin
        report_error("seg_sel does not select exactly one digit");
      end else if (dig >= 2) begin
        check_word($sformatf("seg_led digit %0d", dig), word_t'(seg_led),
                   word_t'(HEX_SEG[shown[4 * dig +: 4]]));
        seen[dig] = 1'b1;
      end
    end
    if (seen[5:2] != 4'hf) begin
      report_timeout("a full display scan");
    end
    finish_test(5);

    // Behavior 6, protocol reset in the middle of a transfer
    @(negedge sys_clk);
    rbp_cmd = CMD_STATUS;
    @(negedge sys_clk);
    rbp_req = 1'b1;
    wait_ack(1'b1, "ack high before the protocol reset");
    check_word("led", word_t'(led), 16'h000b);  // Done, ack and req
    rbp_rst = 1'b1;
    wait_ack(1'b0, "ack low after the protocol reset");
    rbp_rst = 1'b0;
    repeat (4) @(negedge sys_clk);
    check_word("rbp_ack", word_t'(rbp_ack), '0);  // Req still high
    rbp_req = 1'b0;
    repeat (4) @(negedge sys_clk);
    pi_xfer(CMD_READ, 1'b0, w);
    check_word("rbp_data", w, {model_mem[1], model_mem[0]});
    finish_test(6);

    $display("behaviors ok %0d, with errors %0d, checks %0d, errors %0d",
             tests_ok, tests_bad, checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* build.f */
capture_pkg.sv
adc_sampler.sv
capture_ctrl.sv
capture_buffer.sv
host_port.sv
seg_led_hex.sv
capture_top.sv
tb_capture_top.sv

/* run_sim.sh */
#!/bin/sh
# Build the capture testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module tb_capture_top -f build.f -o sim_capture
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/sim_capture > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "test passed" "$LOG"; then
  exit 0
fi
exit 1
